// ==== logic/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data and address width
`define MIPS_XLEN 32

// architectural registers, numbered with 5 bits
`define MIPS_NUM_REGS 32

`define MIPS_RESET_PC 32'h0000_0000

// funct code of syscall, used to halt the core
`define MIPS_SYSCALL_FUNCT 6'h0c

`endif

// ==== logic/mips_pkg.sv ====
`include "mips_cfg.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR      = 6'h08,
        FN_SYSCALL = `MIPS_SYSCALL_FUNCT,
        FN_ADD     = 6'h20,
        FN_SUB     = 6'h22,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // same instruction word seen as R-type or I-type
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } inst_t;

endpackage

// ==== logic/pipe_if.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

interface pipe_if;
    import mips_pkg::*;

    logic                  valid;
    alu_op_e               alu_op;
    logic [`MIPS_XLEN-1:0] val1;
    // register operand or extended immediate
    logic [`MIPS_XLEN-1:0] val2;
    logic [`MIPS_XLEN-1:0] store_data;
    logic [4:0]            dest;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_byte;
    logic                  halt;

    modport src (output valid, alu_op, val1, val2, store_data, dest,
                        reg_write, mem_read, mem_write, is_byte, halt);
    modport dst (input  valid, alu_op, val1, val2, store_data, dest,
                        reg_write, mem_read, mem_write, is_byte, halt);

endinterface

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic [4:0]            rs_num,
    input  logic [4:0]            rt_num,
    output logic [`MIPS_XLEN-1:0] rs_data,
    output logic [`MIPS_XLEN-1:0] rt_data,
    input  logic                  rd_we,
    input  logic [4:0]            rd_num,
    input  logic [`MIPS_XLEN-1:0] rd_data
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];
    logic                  wr_live;

    // r0 never takes a write
    assign wr_live = rd_we && (rd_num != 5'd0);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_num] <= rd_data;
        end
    end

    // write-through so decode sees the value being written this cycle
    assign rs_data = (wr_live && rd_num == rs_num) ? rd_data : regs[rs_num];
    assign rt_data = (wr_live && rd_num == rt_num) ? rd_data : regs[rt_num];

    a_r0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_b)
        (rs_num != 5'd0 || rs_data == '0) && (rt_num != 5'd0 || rt_data == '0)
    );

endmodule

// ==== logic/fetch_decode.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module fetch_decode (
    input  logic                  clk,
    input  logic                  rst_b,
    output logic [`MIPS_XLEN-1:0] inst_addr,
    input  mips_pkg::inst_t       inst,
    output logic [4:0]            rs_num,
    output logic [4:0]            rt_num,
    input  logic [`MIPS_XLEN-1:0] rs_data,
    input  logic [`MIPS_XLEN-1:0] rt_data,
    pipe_if.src                   id_bus
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] next_pc;
    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_zext;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic                  operands_equal;
    logic                  is_syscall;
    logic                  stopped;

    assign inst_addr = pc;
    assign rs_num    = inst.r_fields.rs;
    assign rt_num    = inst.r_fields.rt;

    assign pc_plus4      = pc + 32'd4;
    assign imm_sext      = {{16{inst.i_fields.imm[15]}}, inst.i_fields.imm};
    assign imm_zext      = {16'h0000, inst.i_fields.imm};
    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    // j keeps the top nibble of the next pc
    assign jump_target   = {pc_plus4[31:28], inst[25:0], 2'b00};

    assign operands_equal = (rs_data == rt_data);
    assign is_syscall     = !stopped && inst.r_fields.opcode == OP_RTYPE &&
                            inst.r_fields.funct == FN_SYSCALL;

    always_comb begin
        id_bus.valid      = !stopped;
        id_bus.alu_op     = ALU_PASS_B;
        id_bus.val1       = rs_data;
        id_bus.val2       = rt_data;
        id_bus.store_data = rt_data;
        id_bus.dest       = inst.r_fields.rd;
        id_bus.reg_write  = 1'b0;
        id_bus.mem_read   = 1'b0;
        id_bus.mem_write  = 1'b0;
        id_bus.is_byte    = 1'b0;
        id_bus.halt       = is_syscall;
        next_pc           = pc_plus4;

        case (inst.r_fields.opcode)
            OP_RTYPE: begin
                id_bus.reg_write = 1'b1;
                case (inst.r_fields.funct)
                    FN_ADD: id_bus.alu_op = ALU_ADD;
                    FN_SUB: id_bus.alu_op = ALU_SUB;
                    FN_AND: id_bus.alu_op = ALU_AND;
                    FN_OR:  id_bus.alu_op = ALU_OR;
                    FN_SLT: id_bus.alu_op = ALU_SLT;
                    FN_JR: begin
                        id_bus.reg_write = 1'b0;
                        next_pc          = rs_data;
                    end
                    default: id_bus.reg_write = 1'b0;
                endcase
            end
            OP_ADDI, OP_LW, OP_LB: begin
                id_bus.alu_op    = ALU_ADD;
                id_bus.val2      = imm_sext;
                id_bus.dest      = inst.i_fields.rt;
                id_bus.reg_write = 1'b1;
                id_bus.mem_read  = (inst.i_fields.opcode != OP_ADDI);
                id_bus.is_byte   = (inst.i_fields.opcode == OP_LB);
            end
            OP_ORI: begin
                id_bus.alu_op    = ALU_OR;
                id_bus.val2      = imm_zext;
                id_bus.dest      = inst.i_fields.rt;
                id_bus.reg_write = 1'b1;
            end
            OP_LUI: begin
                // alu moves the immediate into the upper half
                id_bus.alu_op    = ALU_LUI;
                id_bus.val2      = imm_zext;
                id_bus.dest      = inst.i_fields.rt;
                id_bus.reg_write = 1'b1;
            end
            OP_SW, OP_SB: begin
                id_bus.alu_op    = ALU_ADD;
                id_bus.val2      = imm_sext;
                id_bus.mem_write = 1'b1;
                id_bus.is_byte   = (inst.i_fields.opcode == OP_SB);
            end
            OP_BEQ: begin
                if (operands_equal) begin
                    next_pc = branch_target;
                end
            end
            OP_BNE: begin
                if (!operands_equal) begin
                    next_pc = branch_target;
                end
            end
            OP_J:    next_pc = jump_target;
            default: ;
        endcase

        // frozen from the syscall onward
        if (stopped || is_syscall) begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            pc      <= `MIPS_RESET_PC;
            stopped <= 1'b0;
        end else begin
            pc <= next_pc;
            if (is_syscall) begin
                stopped <= 1'b1;
            end
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_b)
        pc[1:0] == 2'b00
    );

endmodule

// ==== logic/id_exe_latch.sv ====
`timescale 1ns/1ps

module id_exe_latch (
    input  logic clk,
    input  logic rst_b,
    pipe_if.dst  id_bus,
    pipe_if.src  ex_bus
);

    // valid qualifies the other held fields
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            ex_bus.valid <= 1'b0;
        end else begin
            ex_bus.valid <= id_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_bus.alu_op     <= id_bus.alu_op;
        ex_bus.val1       <= id_bus.val1;
        ex_bus.val2       <= id_bus.val2;
        ex_bus.store_data <= id_bus.store_data;
        ex_bus.dest       <= id_bus.dest;
        ex_bus.reg_write  <= id_bus.reg_write;
        ex_bus.mem_read   <= id_bus.mem_read;
        ex_bus.mem_write  <= id_bus.mem_write;
        ex_bus.is_byte    <= id_bus.is_byte;
        ex_bus.halt       <= id_bus.halt;
    end

endmodule

// ==== logic/execute_writeback.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module execute_writeback (
    input  logic                  clk,
    input  logic                  rst_b,
    pipe_if.dst                   ex_bus,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output logic [0:3][7:0]       mem_data_in,
    input  logic [0:3][7:0]       mem_data_out,
    output logic                  mem_write_en,
    output logic [3:0]            mem_byte_en,
    output logic                  rd_we,
    output logic [4:0]            rd_num,
    output logic [`MIPS_XLEN-1:0] rd_data,
    output logic                  halted
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0] alu_result;
    logic [`MIPS_XLEN-1:0] load_value;
    logic [1:0]            lane;

    always_comb begin
        case (ex_bus.alu_op)
            ALU_ADD:    alu_result = ex_bus.val1 + ex_bus.val2;
            ALU_SUB:    alu_result = ex_bus.val1 - ex_bus.val2;
            ALU_AND:    alu_result = ex_bus.val1 & ex_bus.val2;
            ALU_OR:     alu_result = ex_bus.val1 | ex_bus.val2;
            ALU_SLT:    alu_result = {31'd0, $signed(ex_bus.val1) < $signed(ex_bus.val2)};
            ALU_LUI:    alu_result = {ex_bus.val2[15:0], 16'h0000};
            ALU_PASS_B: alu_result = ex_bus.val2;
            default:    alu_result = ex_bus.val2;
        endcase
    end

    // big-endian with lane 0 as the most significant byte
    assign lane     = alu_result[1:0];
    assign mem_addr = alu_result;

    assign mem_write_en = ex_bus.valid && ex_bus.mem_write;
    // mem_byte_en[i] enables lane i
    assign mem_byte_en  = ex_bus.is_byte ? (4'b0001 << lane) : 4'b1111;
    // sb puts its byte on every lane and the enable picks one
    assign mem_data_in  = ex_bus.is_byte ? {4{ex_bus.store_data[7:0]}} : ex_bus.store_data;

    always_comb begin
        if (ex_bus.is_byte) begin
            load_value = {{24{mem_data_out[lane][7]}}, mem_data_out[lane]};
        end else begin
            load_value = mem_data_out;
        end
    end

    assign rd_we   = ex_bus.valid && ex_bus.reg_write;
    assign rd_num  = ex_bus.dest;
    assign rd_data = ex_bus.mem_read ? load_value : alu_result;

    // sticky once syscall retires
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            halted <= 1'b0;
        end else if (ex_bus.valid && ex_bus.halt) begin
            halted <= 1'b1;
        end
    end

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (!rst_b)
        ex_bus.valid |-> !(ex_bus.mem_read && ex_bus.mem_write)
    );

    // decode must have frozen before the halt took effect
    a_no_store_after_halt: assert property (
        @(posedge clk) disable iff (!rst_b)
        halted |-> !mem_write_en
    );

    a_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_b)
        (ex_bus.valid && (ex_bus.mem_read || ex_bus.mem_write) && !ex_bus.is_byte)
            |-> (alu_result[1:0] == 2'b00)
    );

endmodule

// ==== logic/mips_core.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_core (
    output logic [`MIPS_XLEN-1:0] inst_addr,
    input  logic [`MIPS_XLEN-1:0] inst,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    input  logic [0:3][7:0]       mem_data_out,
    output logic [0:3][7:0]       mem_data_in,
    output logic                  mem_write_en,
    output logic [3:0]            mem_byte_en,
    output logic                  halted,
    input  logic                  clk,
    input  logic                  rst_b
);

    logic [4:0]            rs_num;
    logic [4:0]            rt_num;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic                  rd_we;
    logic [4:0]            rd_num;
    logic [`MIPS_XLEN-1:0] rd_data;

    pipe_if id_bus ();
    pipe_if ex_bus ();

    regfile u_regfile (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rd_we   (rd_we),
        .rd_num  (rd_num),
        .rd_data (rd_data)
    );

    fetch_decode u_fetch_decode (
        .clk       (clk),
        .rst_b     (rst_b),
        .inst_addr (inst_addr),
        .inst      (inst),
        .rs_num    (rs_num),
        .rt_num    (rt_num),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .id_bus    (id_bus.src)
    );

    id_exe_latch u_id_exe_latch (
        .clk    (clk),
        .rst_b  (rst_b),
        .id_bus (id_bus.dst),
        .ex_bus (ex_bus.src)
    );

    execute_writeback u_execute_writeback (
        .clk          (clk),
        .rst_b        (rst_b),
        .ex_bus       (ex_bus.dst),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out),
        .mem_write_en (mem_write_en),
        .mem_byte_en  (mem_byte_en),
        .rd_we        (rd_we),
        .rd_num       (rd_num),
        .rd_data      (rd_data),
        .halted       (halted)
    );

endmodule

// ==== verification/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

    localparam int    IMEM_WORDS  = 256;
    localparam int    DMEM_BYTES  = 1024;
    localparam int    HALT_CYCLES = 4;
    localparam string GOLDEN_FILE = "verification/mips_core_golden.txt";

    logic            clk = 1'b0;
    logic            rst_b;
    logic [31:0]     inst_addr;
    logic [31:0]     inst;
    logic [31:0]     mem_addr;
    logic [0:3][7:0] mem_data_out;
    logic [0:3][7:0] mem_data_in;
    logic            mem_write_en;
    logic [3:0]      mem_byte_en;
    logic            halted;

    logic [31:0] imem [IMEM_WORDS];
    logic [7:0]  dmem [DMEM_BYTES];

    // expected store log and final words
    logic [31:0] exp_st_addr  [$];
    logic [3:0]  exp_st_be    [$];
    logic [31:0] exp_st_data  [$];
    logic [31:0] exp_fin_addr [$];
    logic [31:0] exp_fin_data [$];

    int prog_count;
    int stores_seen;
    int cycles;
    int cycle_limit;
    int store_errors;
    int mem_errors;
    int ctrl_errors;

    mips_core u_mips_core (
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en),
        .mem_byte_en  (mem_byte_en),
        .halted       (halted),
        .clk          (clk),
        .rst_b        (rst_b)
    );

    always #10 clk = ~clk;

    // combinational fetch and data read with lane 0 at the lowest address
    assign inst = imem[inst_addr[9:2]];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mem_data_out[i] = dmem[{mem_addr[9:2], i[1:0]}];
        end
    end

    always @(posedge clk) begin
        if (rst_b && mem_write_en) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_byte_en[i]) begin
                    dmem[{mem_addr[9:2], i[1:0]}] <= mem_data_in[i];
                end
            end
        end
    end

    always @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return {dmem[{addr[9:2], 2'd0}], dmem[{addr[9:2], 2'd1}],
                dmem[{addr[9:2], 2'd2}], dmem[{addr[9:2], 2'd3}]};
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            // undecoded opcode, runs as a no-op
            imem[i] = {6'h3f, 18'd0, i[7:0]};
        end
        for (int i = 0; i < DMEM_BYTES; i++) begin
            dmem[i] <= i[7:0] ^ {6'd0, i[9:8]};
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          code;
        int          fields;
        logic [7:0]  tag;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] be;
        string       rest;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            ctrl_errors++;
            $display("could not open %s", GOLDEN_FILE);
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                fields = 0;
                code   = 0;
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "P": begin
                        fields = 1;
                        code   = $fscanf(fd, "%h", data);
                        imem[prog_count[7:0]] = data;
                        prog_count++;
                    end
                    "D": begin
                        fields = 2;
                        code   = $fscanf(fd, "%h %h", addr, data);
                        for (int i = 0; i < 4; i++) begin
                            dmem[{addr[9:2], i[1:0]}] <= data[31 - 8 * i -: 8];
                        end
                    end
                    "S": begin
                        fields = 3;
                        code   = $fscanf(fd, "%h %h %h", addr, be, data);
                        exp_st_addr.push_back(addr);
                        exp_st_be.push_back(be[3:0]);
                        exp_st_data.push_back(data);
                    end
                    "F": begin
                        fields = 2;
                        code   = $fscanf(fd, "%h %h", addr, data);
                        exp_fin_addr.push_back(addr);
                        exp_fin_data.push_back(data);
                    end
                    default: begin
                        ctrl_errors++;
                        $display("unknown tag '%c' in %s", tag, GOLDEN_FILE);
                    end
                endcase
                if (fields != 0 && code != fields) begin
                    ctrl_errors++;
                    $display("malformed '%c' entry in %s", tag, GOLDEN_FILE);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_idle();
        assert (!halted && !mem_write_en && inst_addr == 32'h0) else begin
            ctrl_errors++;
            $display("Fail reset: expected halted 0 write_en 0 inst_addr %h, %s %b %b %h",
                     32'h0, "actual", halted, mem_write_en, inst_addr);
        end
    endtask

    task automatic check_store();
        logic [31:0] mask;
        logic [31:0] got;
        int          n;
        n   = stores_seen;
        got = mem_data_in;
        stores_seen++;
        assert (!halted) else begin
            ctrl_errors++;
            $display("store to %h happened after the core halted", mem_addr);
        end
        assert (n < exp_st_addr.size()) else begin
            store_errors++;
            $display("unexpected store to %h beyond the expected ones", mem_addr);
        end
        if (n < exp_st_addr.size()) begin
            // only enabled lanes carry data
            mask = {{8{exp_st_be[n][0]}}, {8{exp_st_be[n][1]}},
                    {8{exp_st_be[n][2]}}, {8{exp_st_be[n][3]}}};
            assert (mem_addr == exp_st_addr[n] && mem_byte_en == exp_st_be[n] &&
                    (got & mask) == (exp_st_data[n] & mask)) else begin
                store_errors++;
                $display("Fail store_%0d: expected %h %b %h, actual %h %b %h", n,
                         exp_st_addr[n], exp_st_be[n], exp_st_data[n] & mask,
                         mem_addr, mem_byte_en, got & mask);
            end
        end
    endtask

    task automatic check_after_halt();
        logic [31:0] word;
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            assert (halted) else begin
                ctrl_errors++;
                $display("halted dropped after the syscall retired");
            end
        end
        assert (stores_seen == exp_st_addr.size()) else begin
            store_errors++;
            $display("Fail store_count: expected %0d, actual %0d",
                     exp_st_addr.size(), stores_seen);
        end
        for (int k = 0; k < exp_fin_addr.size(); k++) begin
            word = read_word(exp_fin_addr[k]);
            assert (word == exp_fin_data[k]) else begin
                mem_errors++;
                $display("Fail final_word_%h: expected %h, actual %h",
                         exp_fin_addr[k], exp_fin_data[k], word);
            end
        end
    endtask

    // mid-cycle sampling of reset state and stores
    always @(negedge clk) begin
        if (!rst_b || cycles == 0) begin
            check_idle();
        end
        if (rst_b && mem_write_en) begin
            check_store();
        end
    end

    initial begin
        rst_b        = 1'b0;
        prog_count   = 0;
        stores_seen  = 0;
        store_errors = 0;
        mem_errors   = 0;
        ctrl_errors  = 0;
        fill_memories();
        load_golden();
        cycle_limit = 4 * prog_count + 50;
        repeat (4) @(posedge clk);
        #1;
        rst_b = 1'b1;
        while (!halted && cycles < cycle_limit) begin
            @(negedge clk);
        end
        assert (halted) else begin
            ctrl_errors++;
            $display("timeout: core never halted within %0d cycles", cycle_limit);
        end
        if (halted) begin
            check_after_halt();
        end
        $display("errors: store %0d, memory %0d, control %0d",
                 store_errors, mem_errors, ctrl_errors);
        if (store_errors + mem_errors + ctrl_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== mips_lite.f ====
+incdir+logic
logic/mips_pkg.sv
logic/pipe_if.sv
logic/regfile.sv
logic/fetch_decode.sv
logic/id_exe_latch.sv
logic/execute_writeback.sv
logic/mips_core.sv
verification/mips_core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := mips_core_tb
FILELIST  := mips_lite.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/mips_core_golden.txt ====
# P word | D addr word | S addr byte_en data | F addr word, all hex
# S data holds only the enabled bytes, byte_en bit 0 is the lane at the lowest address
P 20010005  P 2002fffd  P 00221820  P ac030100   # addi addi add sw
P 00222022  P ac040104  P 3405f0f3  P 3c061234   # sub sw ori lui
P 00a63825  P ac070108  P 00e24024  P ac08010c   # or sw and sw
P 0041482a  P 0022502a  P ac090110  P ac0a0114   # slt slt sw sw
P 800c0200  P 800d0203  P 8c0e0200  P ac0c0118   # lb lb lw sw
P 01ae7820  P ac0f011c  P a0010121  P a00c0122   # add sw sb sb
P 80100122  P ac100124  P 10210001  P ac0001f0   # lb sw beq taken, skipped sw
P 14210001  P ac010128  P 14220001  P ac0001f4   # bne not taken, sw, bne taken, skipped sw
P 08000022  P ac0001f8  P 20110094  P 02200008   # j, skipped sw, addi, jr
P ac0001fc  P ac11012c  P 0000000c  P ac0001e0   # skipped sw, sw, syscall, never fetched
D 00000114 deadbeef  D 00000120 11223344
D 000001f0 cafef00d  D 00000200 80ff7f01
S 00000100 f 00000002   # add 5 + -3
S 00000104 f 00000008   # sub 5 - -3
S 00000108 f 1234f0f3   # or of ori and lui
S 0000010c f 1234f0f1   # and with fffffffd
S 00000110 f 00000001   # slt -3 < 5
S 00000114 f 00000000   # slt 5 < -3
S 00000118 f ffffff80   # lb of the negative byte
S 0000011c f 80ff7f02   # lb 01 plus lw
S 00000121 2 00050000   # sb lane 1
S 00000122 4 00008000   # sb lane 2
S 00000124 f ffffff80   # lb of the stored byte
S 00000128 f 00000005   # after bne not taken
S 0000012c f 00000094   # after jr
F 00000100 00000002  F 00000114 00000000  F 0000011c 80ff7f02
F 00000120 11058044  F 0000012c 00000094  F 000001f0 cafef00d
